/* verilog/busPkg.sv */
////////////////////////////////////////
// Bus unit package
// Bus widths, the AHB-Lite code enums and
// the packed structs shared by the stream
// arbiter, the beat generator and the
// response router
////////////////////////////////////////

package busPkg;

  // Address and data widths of the AHB-Lite port
  localparam int AddrW = 32;
  localparam int DataW = 32;

  // Current owner of the bus, held by the arbiter
  typedef enum logic [1:0] {
    Idle,
    MemRead,
    MemWrite,
    InstrRead
  } busStateT;

  // HBURST codes, only the single and 4-beat kinds are issued
  typedef enum logic [2:0] {
    Single = 3'b000,
    Wrap4  = 3'b010,
    Incr4  = 3'b011
  } hburstT;

  // HTRANS codes, BUSY is never driven by this master
  typedef enum logic [1:0] {
    IdleT  = 2'b00,
    NonSeq = 2'b10,
    Seq    = 2'b11
  } htransT;

  // HSIZE codes up to the 32-bit bus width
  typedef enum logic [2:0] {
    Byte = 3'b000,
    Half = 3'b001,
    Word = 3'b010
  } hsizeT;

  // Request from a stream, held with stable fields until its last ack
  typedef struct packed {
    logic [AddrW-1:0] addr;
    logic             read;
    logic             write;
    hsizeT            size;
    hburstT           burst;
    logic             unsignedLoad;
    logic [DataW-1:0] writeData;
  } busReqT;

  // What the data phase needs to know about its address phase
  typedef struct packed {
    logic [1:0] addrLow;
    hsizeT      size;
    logic       unsignedLoad;
    logic       write;
    busStateT   owner;
    logic       active;
  } dataPhaseT;

endpackage

/* verilog/busArbiter.sv */
////////////////////////////////////////
// Stream arbiter
// Decides which stream owns the AHB port.
// LSU reads win over LSU writes, which win
// over IFU fetches; an owner keeps the bus
// until its transfer is done
////////////////////////////////////////

`timescale 1ns/1ps

module busArbiter (
  input  logic             clk,
  input  logic             rstN,
  input  busPkg::busReqT   ifuReq,
  input  busPkg::busReqT   lsuReq,
  input  logic             transDone,
  output busPkg::busStateT state,
  output busPkg::busStateT nextState,
  output logic             ifuInit,
  output logic             lsuInit
);

  logic lsuGranted;
  logic lsuOwns;

  ////////////////////////////////////////
  // Ownership register
  ////////////////////////////////////////

  // The state always follows nextState, stalls are handled by transDone
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= busPkg::Idle;
    end else begin
      state <= nextState;
    end
  end

  ////////////////////////////////////////
  // Next owner
  ////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      busPkg::Idle: begin
        // Data accesses go first when both streams ask in the same cycle
        if (lsuReq.read)
          nextState = busPkg::MemRead;
        else if (lsuReq.write)
          nextState = busPkg::MemWrite;
        else if (ifuReq.read)
          nextState = busPkg::InstrRead;
      end
      busPkg::MemRead, busPkg::MemWrite: begin
        // A waiting fetch takes over in the cycle the data transfer ends
        if (transDone && ifuReq.read)
          nextState = busPkg::InstrRead;
        else if (transDone)
          nextState = busPkg::Idle;
      end
      busPkg::InstrRead: begin
        // A load or store that arrived mid-burst waits for the last fetch beat
        if (transDone && lsuReq.read)
          nextState = busPkg::MemRead;
        else if (transDone && lsuReq.write)
          nextState = busPkg::MemWrite;
        else if (transDone)
          nextState = busPkg::Idle;
      end
      default: begin
        nextState = busPkg::Idle;
      end
    endcase
  end

  ////////////////////////////////////////
  // Grant pulses
  ////////////////////////////////////////

  assign lsuGranted = (nextState == busPkg::MemRead) || (nextState == busPkg::MemWrite);
  assign lsuOwns    = (state == busPkg::MemRead) || (state == busPkg::MemWrite);

  // Init is high only in the cycle a stream is newly handed the bus
  assign lsuInit = lsuGranted && !lsuOwns;
  assign ifuInit = (nextState == busPkg::InstrRead) && (state != busPkg::InstrRead);

endmodule

/* verilog/ahbBeatGen.sv */
////////////////////////////////////////
// AHB beat generator
// Drives the address phase for the stream
// that owns the bus, counts burst beats,
// wraps or increments the address and
// tracks the data phase of each beat
////////////////////////////////////////

`timescale 1ns/1ps

module ahbBeatGen (
  input  logic                     clk,
  input  logic                     rstN,
  input  busPkg::busReqT           ifuReq,
  input  busPkg::busReqT           lsuReq,
  input  busPkg::busStateT         state,
  input  busPkg::busStateT         nextState,
  input  logic                     hready,
  output logic [busPkg::AddrW-1:0] haddr,
  output logic                     hwrite,
  output busPkg::hsizeT            hsize,
  output busPkg::hburstT           hburst,
  output busPkg::htransT           htrans,
  output logic [busPkg::DataW-1:0] hwdata,
  output logic                     transDone,
  output busPkg::dataPhaseT        dataPhase
);

  logic                     grantLsu;
  busPkg::busReqT           req;
  logic                     newXfer;
  logic [1:0]               beatCnt;
  logic                     issuedAll;
  logic [1:0]               beatIdx;
  logic                     issuing;
  logic                     lastBeat;
  logic                     addrAccept;
  logic [busPkg::AddrW-1:0] incrAddr;
  logic [busPkg::AddrW-1:0] wrapAddr;
  logic [busPkg::DataW-1:0] storeData;
  logic                     dpActive;
  busPkg::busStateT         dpOwner;
  logic [1:0]               dpAddrLow;
  busPkg::hsizeT            dpSize;
  logic                     dpUnsigned;
  logic                     dpWrite;

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  // The owner is taken from nextState so a fresh request sees its address this cycle
  assign grantLsu = (nextState == busPkg::MemRead) || (nextState == busPkg::MemWrite);
  assign req      = grantLsu ? lsuReq : ifuReq;

  // A change of owner starts a new transfer at beat 0
  assign newXfer = nextState != state;
  assign beatIdx = newXfer ? 2'd0 : beatCnt;
  assign issuing = (nextState != busPkg::Idle) && (newXfer || !issuedAll);

  // Write bursts are not supported, so stores always go out as single beats
  assign hburst   = (nextState == busPkg::MemWrite) ? busPkg::Single : req.burst;
  assign lastBeat = (hburst == busPkg::Single) || (beatIdx == 2'd3);
  assign hwrite   = nextState == busPkg::MemWrite;
  assign hsize    = req.size;

  always_comb begin
    if (!issuing)
      htrans = busPkg::IdleT;
    else if (beatIdx == 2'd0)
      htrans = busPkg::NonSeq;
    else
      htrans = busPkg::Seq;
  end

  assign addrAccept = hready && (htrans != busPkg::IdleT);

  // Word beats step by 4, a wrap stays inside the 16-byte aligned block
  assign incrAddr = req.addr + {{(busPkg::AddrW-4){1'b0}}, beatIdx, 2'b00};
  assign wrapAddr = {req.addr[busPkg::AddrW-1:4], req.addr[3:2] + beatIdx, req.addr[1:0]};

  always_comb begin
    case (hburst)
      busPkg::Wrap4: haddr = wrapAddr;
      busPkg::Incr4: haddr = incrAddr;
      default:       haddr = req.addr;
    endcase
  end

  ////////////////////////////////////////
  // Beat counter
  ////////////////////////////////////////

  // Frozen while HREADY is low, so the address phase holds
  always_ff @(posedge clk) begin
    if (!rstN) begin
      beatCnt   <= 2'd0;
      issuedAll <= 1'b0;
    end else if (addrAccept) begin
      beatCnt   <= beatIdx + 2'd1;
      issuedAll <= lastBeat;
    end else if (newXfer) begin
      beatCnt   <= 2'd0;
      issuedAll <= 1'b0;
    end
  end

  // The last beat is in its data phase once everything has been issued
  assign transDone = dpActive && hready && issuedAll;

  ////////////////////////////////////////
  // Write data and data phase
  ////////////////////////////////////////

  // Store data comes from the low bits and is copied onto every byte lane
  always_comb begin
    case (lsuReq.size)
      busPkg::Byte: storeData = {(busPkg::DataW/8){lsuReq.writeData[7:0]}};
      busPkg::Half: storeData = {(busPkg::DataW/16){lsuReq.writeData[15:0]}};
      default:      storeData = lsuReq.writeData;
    endcase
  end

  // HWDATA lags its address phase by one cycle as AHB requires
  always_ff @(posedge clk) begin
    if (addrAccept && hwrite) begin
      hwdata <= storeData;
    end
  end

  // A new data phase starts only when the previous one has completed
  always_ff @(posedge clk) begin
    if (!rstN) begin
      dpActive <= 1'b0;
      dpOwner  <= busPkg::Idle;
    end else if (hready) begin
      dpActive <= addrAccept;
      dpOwner  <= nextState;
    end
  end

  always_ff @(posedge clk) begin
    if (addrAccept) begin
      dpAddrLow  <= haddr[1:0];
      dpSize     <= hsize;
      dpUnsigned <= req.unsignedLoad;
      dpWrite    <= hwrite;
    end
  end

  assign dataPhase = '{addrLow: dpAddrLow, size: dpSize, unsignedLoad: dpUnsigned,
                       write: dpWrite, owner: dpOwner, active: dpActive};

endmodule

/* verilog/respRouter.sv */
////////////////////////////////////////
// Response router
// Turns completed data phases into acks for
// the owning stream and aligns and extends
// LSU load data
////////////////////////////////////////

`timescale 1ns/1ps

module respRouter (
  input  logic [busPkg::DataW-1:0] hrdata,
  input  logic                     hready,
  input  busPkg::dataPhaseT        dataPhase,
  output logic                     ifuAck,
  output logic                     lsuAck,
  output logic [busPkg::DataW-1:0] ifuRdata,
  output logic [busPkg::DataW-1:0] lsuRdata
);

  logic                     dataDone;
  logic                     lsuOwner;
  logic [busPkg::DataW-1:0] laneData;
  logic                     byteSign;
  logic                     halfSign;

  ////////////////////////////////////////
  // Acknowledges
  ////////////////////////////////////////

  // A data phase ends in the first cycle with HREADY high
  assign dataDone = dataPhase.active && hready;
  assign lsuOwner = (dataPhase.owner == busPkg::MemRead) ||
                    (dataPhase.owner == busPkg::MemWrite);

  // Only one owner is recorded per data phase, so the acks never overlap
  assign ifuAck = dataDone && (dataPhase.owner == busPkg::InstrRead);
  assign lsuAck = dataDone && lsuOwner;

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  // Fetches always use full words
  assign ifuRdata = hrdata;

  // Move the addressed lane down to bit 0
  assign laneData = hrdata >> {dataPhase.addrLow, 3'b000};

  // Sign bits are forced low for unsigned loads
  assign byteSign = laneData[7] && !dataPhase.unsignedLoad;
  assign halfSign = laneData[15] && !dataPhase.unsignedLoad;

  always_comb begin
    case (dataPhase.size)
      busPkg::Byte: lsuRdata = {{(busPkg::DataW-8){byteSign}}, laneData[7:0]};
      busPkg::Half: lsuRdata = {{(busPkg::DataW-16){halfSign}}, laneData[15:0]};
      default:      lsuRdata = hrdata;
    endcase
  end

endmodule

/* verilog/busUnit.sv */
////////////////////////////////////////
// AHB-Lite bus unit
// Shares one AHB-Lite master port between
// the instruction fetch and load/store
// streams of the core
////////////////////////////////////////

`timescale 1ns/1ps

module busUnit (
  input  logic                     clk,
  input  logic                     rstN,
  // Stream requests
  input  busPkg::busReqT           ifuReq,
  input  busPkg::busReqT           lsuReq,
  // Responses to the fetch stream
  output logic                     ifuAck,
  output logic                     ifuInit,
  output logic [busPkg::DataW-1:0] ifuRdata,
  // Responses to the load/store stream
  output logic                     lsuAck,
  output logic                     lsuInit,
  output logic [busPkg::DataW-1:0] lsuRdata,
  // AHB-Lite master port
  input  logic [busPkg::DataW-1:0] hrdata,
  input  logic                     hready,
  input  logic                     hresp,
  output logic [busPkg::AddrW-1:0] haddr,
  output logic [busPkg::DataW-1:0] hwdata,
  output logic                     hwrite,
  output busPkg::hsizeT            hsize,
  output busPkg::hburstT           hburst,
  output busPkg::htransT           htrans
);

  busPkg::busStateT  state;
  busPkg::busStateT  nextState;
  logic              transDone;
  busPkg::dataPhaseT dataPhase;

  // HRESP is only watched by the protocol checks, errors are never raised

  // Decode: who owns the bus
  busArbiter arbiter (
    .clk       (clk),
    .rstN      (rstN),
    .ifuReq    (ifuReq),
    .lsuReq    (lsuReq),
    .transDone (transDone),
    .state     (state),
    .nextState (nextState),
    .ifuInit   (ifuInit),
    .lsuInit   (lsuInit)
  );

  // Execute: address phases and beat counting
  ahbBeatGen beatGen (
    .clk       (clk),
    .rstN      (rstN),
    .ifuReq    (ifuReq),
    .lsuReq    (lsuReq),
    .state     (state),
    .nextState (nextState),
    .hready    (hready),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .hburst    (hburst),
    .htrans    (htrans),
    .hwdata    (hwdata),
    .transDone (transDone),
    .dataPhase (dataPhase)
  );

  // Result: acks and read data back to the streams
  respRouter router (
    .hrdata    (hrdata),
    .hready    (hready),
    .dataPhase (dataPhase),
    .ifuAck    (ifuAck),
    .lsuAck    (lsuAck),
    .ifuRdata  (ifuRdata),
    .lsuRdata  (lsuRdata)
  );

endmodule

/* dv/ahbMemModel.sv */
////////////////////////////////////////
// AHB-Lite memory model
// 1 KB slave with byte-lane writes and
// random wait states in every data phase
////////////////////////////////////////

`timescale 1ns/1ps

module ahbMemModel (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic [busPkg::AddrW-1:0] haddr,
  input  logic [busPkg::DataW-1:0] hwdata,
  input  logic                     hwrite,
  input  busPkg::hsizeT            hsize,
  input  busPkg::htransT           htrans,
  output logic [busPkg::DataW-1:0] hrdata,
  output logic                     hready,
  output logic                     hresp
);

  logic [31:0]              mem [256];
  logic                     dpValid;
  logic                     dpWrite;
  logic [busPkg::AddrW-1:0] dpAddr;
  busPkg::hsizeT            dpSize;
  logic [1:0]               waitCnt;

  // Preload depends on every address bit so misrouted beats show up
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = (i * 4 * 32'h9e3779b1) ^ 32'h5a5a0000;
    end
  end

  // The model never signals an error
  assign hresp  = 1'b0;
  assign hrdata = mem[dpAddr[9:2]];

  always @(posedge clk) begin
    logic [1:0] newWait;
    if (!rstN) begin
      dpValid <= 1'b0;
      dpWrite <= 1'b0;
      dpAddr  <= '0;
      dpSize  <= busPkg::Word;
      hready  <= 1'b1;
      waitCnt <= 2'd0;
    end else if (hready) begin
      // The current data phase completes at this edge
      if (dpValid && dpWrite) begin
        case (dpSize)
          busPkg::Byte: mem[dpAddr[9:2]][dpAddr[1:0]*8 +: 8] <= hwdata[dpAddr[1:0]*8 +: 8];
          busPkg::Half: mem[dpAddr[9:2]][dpAddr[1]*16 +: 16] <= hwdata[dpAddr[1]*16 +: 16];
          default:      mem[dpAddr[9:2]] <= hwdata;
        endcase
      end
      dpValid <= htrans != busPkg::IdleT;
      dpWrite <= hwrite;
      dpAddr  <= haddr;
      dpSize  <= hsize;
      if (htrans != busPkg::IdleT) begin
        newWait = 2'($urandom_range(0, 2));
        waitCnt <= newWait;
        hready  <= newWait == 2'd0;
      end
    end else begin
      // Count down the wait states of the data phase
      waitCnt <= waitCnt - 2'd1;
      hready  <= waitCnt == 2'd1;
    end
  end

endmodule

/* dv/busUnit_assert.sv */
////////////////////////////////////////
// Bus unit protocol checks
// AHB-Lite rules and stream ack rules,
// bound into the bus unit
////////////////////////////////////////

`timescale 1ns/1ps

module busUnitAssert (
  input logic                     clk,
  input logic                     rstN,
  input busPkg::busReqT           ifuReq,
  input busPkg::busReqT           lsuReq,
  input logic                     ifuAck,
  input logic                     lsuAck,
  input logic                     ifuInit,
  input logic                     lsuInit,
  input logic [busPkg::AddrW-1:0] haddr,
  input logic [busPkg::DataW-1:0] hwdata,
  input logic                     hwrite,
  input busPkg::hsizeT            hsize,
  input busPkg::hburstT           hburst,
  input busPkg::htransT           htrans,
  input logic                     hready,
  input logic                     hresp,
  input busPkg::dataPhaseT        dataPhase
);

  // Leaving reset the port is idle and quiet
  assert property (@(posedge clk) $rose(rstN) |->
    htrans == busPkg::IdleT && !ifuAck && !lsuAck && !ifuInit && !lsuInit && !dataPhase.active)
    else $error("bus not idle after reset");

  // Grants only go to a stream that asks
  assert property (@(posedge clk) disable iff (!rstN)
    (ifuInit |-> ifuReq.read) and (lsuInit |-> lsuReq.read || lsuReq.write))
    else $error("init without a request");

  assert property (@(posedge clk) disable iff (!rstN) !(ifuAck && lsuAck))
    else $error("both streams acked together");

  assert property (@(posedge clk) disable iff (!rstN) !hresp)
    else $error("error response seen");

  // A stalled address phase holds address and control
  assert property (@(posedge clk) disable iff (!rstN)
    (htrans != busPkg::IdleT && !hready) |=>
      $stable(haddr) && $stable(htrans) && $stable(hburst) && $stable(hwrite) && $stable(hsize))
    else $error("address phase changed while stalled");

  // Write data holds while its data phase is stretched
  assert property (@(posedge clk) disable iff (!rstN)
    (dataPhase.active && dataPhase.write && !hready) |=> $stable(hwdata))
    else $error("hwdata changed while stalled");

  // A sequential beat follows an accepted beat of the same burst
  assert property (@(posedge clk) disable iff (!rstN)
    (htrans == busPkg::Seq && $past(hready)) |-> $past(htrans) != busPkg::IdleT &&
    (hburst == busPkg::Incr4 ? haddr == $past(haddr) + 32'd4 :
     (haddr[31:4] == $past(haddr[31:4]) && haddr[3:2] == $past(haddr[3:2]) + 2'd1)))
    else $error("burst address step broken");

endmodule

/* dv/busUnitTb.sv */
////////////////////////////////////////
// Bus unit testbench
// Drives both streams against a memory
// model and checks data against a copy
////////////////////////////////////////

`timescale 1ns/1ps

module busUnitTb;

  logic clk, rstN, ifuAck, ifuInit, lsuAck, lsuInit, hready, hresp, hwrite;
  logic [31:0] ifuRdata, lsuRdata, hrdata, haddr, hwdata;
  busPkg::busReqT ifuReq, lsuReq;
  busPkg::hsizeT  hsize;
  busPkg::hburstT hburst;
  busPkg::htransT htrans;
  logic [31:0] refMem [256];
  int errors, tests, cycle, lsuInitAt, ifuInitAt, ifuDoneAt;

  busUnit UUT (.*);

  ahbMemModel memModel (.clk, .rstN, .haddr, .hwdata, .hwrite, .hsize, .htrans,
                        .hrdata, .hready, .hresp);

  bind busUnit busUnitAssert checks (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Grant times, sampled after the falling-edge drive settles
  always @(negedge clk) begin
    #1;
    cycle++;
    if (lsuInit)
      lsuInitAt = cycle;
    if (ifuInit)
      ifuInitAt = cycle;
  end

  task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // Expected load result taken from the reference copy with the lane picked and extended
  function automatic logic [31:0] expectLoad(logic [31:0] a, busPkg::hsizeT sz, bit uns);
    logic [31:0] w;
    w = refMem[a[9:2]] >> (a[1:0] * 8);
    case (sz)
      busPkg::Byte: return uns ? {24'd0, w[7:0]} : {{24{w[7]}}, w[7:0]};
      busPkg::Half: return uns ? {16'd0, w[15:0]} : {{16{w[15]}}, w[15:0]};
      default:      return refMem[a[9:2]];
    endcase
  endfunction

  task automatic lsuAccess(string name, logic [31:0] a, bit wr, busPkg::hsizeT sz, bit uns,
                           logic [31:0] wdata);
    int t;
    @(negedge clk);
    lsuReq = '{addr: a, read: !wr, write: wr, size: sz, burst: busPkg::Single,
               unsignedLoad: uns, writeData: wdata};
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!lsuAck && t < 200);
    if (!lsuAck) begin
      $display("%s: the LSU access at %h got no ack in 200 cycles", name, a);
      errors++;
    end else if (!wr) begin
      compare(name, expectLoad(a, sz, uns), lsuRdata);
    end else begin
      // Only the addressed lanes of the copy change
      case (sz)
        busPkg::Byte: refMem[a[9:2]][a[1:0]*8 +: 8] = wdata[7:0];
        busPkg::Half: refMem[a[9:2]][a[1]*16 +: 16] = wdata[15:0];
        default:      refMem[a[9:2]] = wdata;
      endcase
    end
    @(negedge clk);
    lsuReq.read  = 1'b0;
    lsuReq.write = 1'b0;
  endtask

  task automatic ifuBurst(string name, logic [31:0] a, busPkg::hburstT bt);
    int t;
    logic [31:0] ea;
    @(negedge clk);
    ifuReq = '{addr: a, read: 1'b1, write: 1'b0, size: busPkg::Word, burst: bt,
               unsignedLoad: 1'b0, writeData: '0};
    for (int b = 0; b < 4; b++) begin
      t = 0;
      do begin
        @(negedge clk);
        t++;
      end while (!ifuAck && t < 200);
      if (!ifuAck) begin
        $display("%s: fetch beat %0d from %h got no ack in 200 cycles", name, b, a);
        errors++;
        break;
      end
      // An increment steps on by a word while a wrap stays in the 16-byte line
      if (bt == busPkg::Incr4)
        ea = a + 32'(b * 4);
      else
        ea = (a & ~32'hf) | ((a + 32'(b * 4)) & 32'hf);
      compare(name, refMem[ea[9:2]], ifuRdata);
    end
    ifuDoneAt = cycle;
    @(negedge clk);
    ifuReq.read = 1'b0;
  endtask

  task automatic endTest(string name, int errsBefore);
    tests++;
    $display("test %s finished with %0d errors", name, errors - errsBefore);
  endtask

  initial begin
    int e;
    void'($urandom(32'hf6f9));
    errors = 0;
    tests  = 0;
    cycle  = 0;
    ifuReq = '0;
    lsuReq = '0;
    rstN   = 1'b0;
    for (int i = 0; i < 256; i++) begin
      refMem[i] = (i * 4 * 32'h9e3779b1) ^ 32'h5a5a0000;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    repeat (4) @(negedge clk);

    e = errors;
    for (int off = 0; off < 4; off++) begin
      for (int uns = 0; uns < 2; uns++) begin
        lsuAccess("loads", 32'h20 + 32'(off), 1'b0, busPkg::Byte, uns[0], '0);
        lsuAccess("loads", 32'h20 + 32'(off & 2), 1'b0, busPkg::Half, uns[0], '0);
      end
      lsuAccess("loads", 32'h60 + 32'(off * 4), 1'b0, busPkg::Word, 1'b0, '0);
    end
    endTest("loads", e);

    e = errors;
    lsuAccess("stores", 32'h31, 1'b1, busPkg::Byte, 1'b0, $urandom);
    lsuAccess("stores", 32'h30, 1'b0, busPkg::Word, 1'b0, '0);
    lsuAccess("stores", 32'h36, 1'b1, busPkg::Half, 1'b0, $urandom);
    lsuAccess("stores", 32'h34, 1'b0, busPkg::Word, 1'b0, '0);
    lsuAccess("stores", 32'h38, 1'b1, busPkg::Word, 1'b0, $urandom);
    lsuAccess("stores", 32'h38, 1'b0, busPkg::Word, 1'b0, '0);
    endTest("stores", e);

    e = errors;
    ifuBurst("bursts", 32'h48, busPkg::Incr4);
    ifuBurst("bursts", 32'h48, busPkg::Wrap4);
    ifuBurst("bursts", 32'h5c, busPkg::Wrap4);
    endTest("bursts", e);

    e = errors;
    fork
      ifuBurst("arbitration", 32'h84, busPkg::Wrap4);
      lsuAccess("arbitration", 32'h90, 1'b0, busPkg::Word, 1'b0, '0);
    join
    if (!(lsuInitAt < ifuInitAt)) begin
      $display("arbitration: the fetch was granted before the simultaneous load");
      errors++;
    end
    fork
      ifuBurst("arbitration", 32'ha8, busPkg::Incr4);
      begin
        @(negedge clk);
        lsuAccess("arbitration", 32'hb4, 1'b0, busPkg::Word, 1'b0, '0);
      end
    join
    if (lsuInitAt <= ifuDoneAt) begin
      $display("arbitration: a load took the bus before the fetch burst ended");
      errors++;
    end
    endTest("arbitration", e);

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* list.f */
verilog/busPkg.sv
verilog/busArbiter.sv
verilog/ahbBeatGen.sv
verilog/respRouter.sv
verilog/busUnit.sv
dv/ahbMemModel.sv
dv/busUnit_assert.sv
dv/busUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bus unit regression with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module busUnitTb -f list.f -o simBusUnit \
  2>&1 | tee build.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/simBusUnit 2>&1 | tee sim.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0
